// File: exec_pkg.sv
`default_nettype none

package exec_pkg;

    // datapath width
    localparam int XLEN = 64;

    // one multiplier bit is consumed per step
    localparam int MUL_STEPS = 64;

    // wide enough to count up to MUL_STEPS
    localparam int STEP_W = 7;

    // execute stage operations
    typedef enum logic [4:0] {
        ALU_ADD      = 5'd0,
        ALU_SUB      = 5'd1,
        ALU_RETURN_A = 5'd2,
        ALU_RETURN_B = 5'd3,
        ALU_XOR      = 5'd4,
        ALU_OR       = 5'd5,
        ALU_AND      = 5'd6,
        ALU_SLL      = 5'd7,
        ALU_SRL      = 5'd8,
        ALU_SRA      = 5'd9,
        ALU_SLT      = 5'd10,
        ALU_SLTU     = 5'd11,
        ALU_EQ       = 5'd12,
        // greater or equal, signed
        ALU_LOE      = 5'd13,
        // greater or equal, unsigned
        ALU_LOEU     = 5'd14,
        ALU_MUL      = 5'd15,
        ALU_DIV      = 5'd16,
        ALU_DIVU     = 5'd17,
        ALU_REM      = 5'd18,
        ALU_REMU     = 5'd19
    } alu_op_e;

    // first operand source
    typedef enum logic [1:0] {
        SEL_A_PC  = 2'd0,
        SEL_A_RS1 = 2'd1
    } sel_a_e;

    // second operand source, code 3 falls back to imm
    typedef enum logic [1:0] {
        SEL_B_IMM = 2'd0,
        SEL_B_RS2 = 2'd1,
        SEL_B_CSR = 2'd2
    } sel_b_e;

    // operand word, seen whole or as two 32-bit halves
    typedef union packed {
        logic [XLEN-1:0] word;
        struct packed {
            logic [31:0] hi;
            logic [31:0] lo;
        } half;
    } op_word_u;

endpackage

`default_nettype wire

// File: alu_logic.sv
`default_nettype none

module alu_logic (
    input  wire logic [exec_pkg::XLEN-1:0] pc,
    input  wire logic [exec_pkg::XLEN-1:0] rs1,
    input  wire logic [exec_pkg::XLEN-1:0] rs2,
    input  wire logic [exec_pkg::XLEN-1:0] csr,
    input  wire logic [exec_pkg::XLEN-1:0] imm,
    input  wire exec_pkg::sel_a_e          sel_a,
    input  wire exec_pkg::sel_b_e          sel_b,
    input  wire logic                      rs1to32,
    input  wire exec_pkg::alu_op_e         operate,
    output logic      [exec_pkg::XLEN-1:0] a,
    output logic      [exec_pkg::XLEN-1:0] b,
    output logic      [exec_pkg::XLEN-1:0] comb_res
);
    import exec_pkg::*;

    op_word_u               rs1_w;
    op_word_u               a_w;
    logic [5:0]             shamt;
    logic signed [XLEN-1:0] a_s;
    logic signed [XLEN-1:0] b_s;
    logic                   lt_s;
    logic                   lt_u;
    logic                   eq;
    logic [31:0]            sra_lo;
    logic                   div_zero;
    logic                   div_ovf;
    logic [XLEN-1:0]        quot_s_raw;
    logic [XLEN-1:0]        rem_s_raw;
    logic [XLEN-1:0]        quot_s;
    logic [XLEN-1:0]        rem_s;
    logic [XLEN-1:0]        quot_u;
    logic [XLEN-1:0]        rem_u;

    // operand a, rs1 may be cut down to its low word
    always_comb begin
        rs1_w.word = rs1;
        if (sel_a == SEL_A_RS1) begin
            if (rs1to32) begin
                a = {32'b0, rs1_w.half.lo};
            end else begin
                a = rs1;
            end
        end else begin
            a = pc;
        end
    end

    always_comb begin
        case (sel_b)
            SEL_B_RS2: b = rs2;
            SEL_B_CSR: b = csr;
            default:   b = imm;
        endcase
    end

    assign a_s   = a;
    assign b_s   = b;
    assign shamt = b[5:0];

    assign lt_s = a_s < b_s;
    assign lt_u = a < b;
    assign eq   = a == b;

    // 32-bit arithmetic shift keeps the sign of bit 31
    always_comb begin
        a_w.word = a;
        sra_lo   = $signed(a_w.half.lo) >>> shamt;
    end

    // RISC-V special cases for zero divisor and signed overflow
    assign div_zero = b == '0;
    assign div_ovf  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == {XLEN{1'b1}});

    // signed results kept in their own statements so the operands stay signed
    assign quot_s_raw = a_s / b_s;
    assign rem_s_raw  = a_s % b_s;

    always_comb begin
        if (div_zero) begin
            quot_s = {XLEN{1'b1}};
            rem_s  = a;
            quot_u = {XLEN{1'b1}};
            rem_u  = a;
        end else begin
            quot_u = a / b;
            rem_u  = a % b;
            if (div_ovf) begin
                quot_s = a;
                rem_s  = '0;
            end else begin
                quot_s = quot_s_raw;
                rem_s  = rem_s_raw;
            end
        end
    end

    always_comb begin
        case (operate)
            ALU_ADD:      comb_res = a + b;
            ALU_SUB:      comb_res = a - b;
            ALU_RETURN_A: comb_res = a;
            ALU_RETURN_B: comb_res = b;
            ALU_XOR:      comb_res = a ^ b;
            ALU_OR:       comb_res = a | b;
            ALU_AND:      comb_res = a & b;
            ALU_SLL:      comb_res = a << shamt;
            ALU_SRL:      comb_res = a >> shamt;
            ALU_SRA: begin
                if (rs1to32) begin
                    comb_res = {32'b0, sra_lo};
                end else begin
                    comb_res = a_s >>> shamt;
                end
            end
            ALU_SLT:      comb_res = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:     comb_res = {{(XLEN-1){1'b0}}, lt_u};
            ALU_EQ:       comb_res = {{(XLEN-1){1'b0}}, eq};
            ALU_LOE:      comb_res = {{(XLEN-1){1'b0}}, ~lt_s};
            ALU_LOEU:     comb_res = {{(XLEN-1){1'b0}}, ~lt_u};
            ALU_DIV:      comb_res = quot_s;
            ALU_DIVU:     comb_res = quot_u;
            ALU_REM:      comb_res = rem_s;
            ALU_REMU:     comb_res = rem_u;
            // product comes from the multi-cycle multiplier
            ALU_MUL:      comb_res = '0;
            default:      comb_res = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: mul_shift_add.sv
`default_nettype none

module mul_shift_add (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      mul_start,
    input  wire logic                      mul_busy,
    input  wire logic [exec_pkg::XLEN-1:0] a,
    input  wire logic [exec_pkg::XLEN-1:0] b,
    output logic      [exec_pkg::XLEN-1:0] mul_res
);
    import exec_pkg::*;

    // multiplicand moves left, multiplier moves right
    logic [XLEN-1:0]      mcand;
    logic [MUL_STEPS-1:0] mplier;
    logic [XLEN-1:0]      acc;
    logic [XLEN-1:0]      partial;
    logic [XLEN-1:0]      acc_next;

    assign partial  = mplier[0] ? mcand : '0;
    assign acc_next = acc + partial;

    // includes the current step, so the final step edge sees the full product
    assign mul_res = acc_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc    <= '0;
            mplier <= '0;
        end else if (mul_start) begin
            acc    <= '0;
            mplier <= b;
        end else if (mul_busy) begin
            acc    <= acc_next;
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand <= a;
        end else if (mul_busy) begin
            mcand <= mcand << 1;
        end
    end

endmodule

`default_nettype wire

// File: mul_step_counter.sv
`default_nettype none

module mul_step_counter (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic mul_start,
    input  wire logic mul_busy,
    output logic      last_step
);
    import exec_pkg::*;

    // busy cycles completed since the start pulse
    logic [STEP_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (mul_start) begin
            count <= '0;
        end else if (mul_busy) begin
            count <= count + 1'b1;
        end
    end

    // high through the cycle whose edge performs the final step
    assign last_step = mul_busy && (count == STEP_W'(MUL_STEPS - 1));

endmodule

`default_nettype wire

// File: exec_ctrl.sv
`default_nettype none

module exec_ctrl (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              flush,
    input  wire logic              last_step,
    input  wire exec_pkg::alu_op_e operate,
    output logic                   mul_start,
    output logic                   mul_busy,
    output logic                   alu_wait,
    output logic                   res_load_comb,
    output logic                   res_load_mul
);
    import exec_pkg::*;

    // two states, low is idle and high is busy
    logic busy;
    logic is_mul;

    assign is_mul = operate == ALU_MUL;

    // idle decisions, a flushed opcode neither starts nor loads
    assign mul_start     = !busy && is_mul && !flush;
    assign res_load_comb = !busy && !is_mul && !flush;

    // datapath steps only while the multiply is alive
    assign mul_busy     = busy && !flush;
    assign res_load_mul = mul_busy && last_step;

    // upstream stall for the whole multiply
    assign alu_wait = busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (busy) begin
            // cancel or completion both go back to idle
            if (flush || last_step) begin
                busy <= 1'b0;
            end
        end else if (mul_start) begin
            busy <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: exec_unit.sv
`default_nettype none

module exec_unit (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      flush,
    input  wire exec_pkg::alu_op_e         operate,
    input  wire exec_pkg::sel_a_e          sel_a,
    input  wire exec_pkg::sel_b_e          sel_b,
    input  wire logic                      rs1to32,
    input  wire logic [exec_pkg::XLEN-1:0] pc,
    input  wire logic [exec_pkg::XLEN-1:0] rs1,
    input  wire logic [exec_pkg::XLEN-1:0] rs2,
    input  wire logic [exec_pkg::XLEN-1:0] csr,
    input  wire logic [exec_pkg::XLEN-1:0] imm,
    output logic      [exec_pkg::XLEN-1:0] res,
    output logic                           alu_wait
);
    import exec_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] comb_res;
    logic [XLEN-1:0] mul_res;
    logic            mul_start;
    logic            mul_busy;
    logic            last_step;
    logic            res_load_comb;
    logic            res_load_mul;

    alu_logic u_alu_logic (
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr      (csr),
        .imm      (imm),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .rs1to32  (rs1to32),
        .operate  (operate),
        .a        (a),
        .b        (b),
        .comb_res (comb_res)
    );

    exec_ctrl u_exec_ctrl (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .last_step     (last_step),
        .operate       (operate),
        .mul_start     (mul_start),
        .mul_busy      (mul_busy),
        .alu_wait      (alu_wait),
        .res_load_comb (res_load_comb),
        .res_load_mul  (res_load_mul)
    );

    mul_step_counter u_mul_step_counter (
        .clk       (clk),
        .rst       (rst),
        .mul_start (mul_start),
        .mul_busy  (mul_busy),
        .last_step (last_step)
    );

    mul_shift_add u_mul_shift_add (
        .clk       (clk),
        .rst       (rst),
        .mul_start (mul_start),
        .mul_busy  (mul_busy),
        .a         (a),
        .b         (b),
        .mul_res   (mul_res)
    );

    // result register, the two strobes never overlap
    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else if (res_load_mul) begin
            res <= mul_res;
        end else if (res_load_comb) begin
            res <= comb_res;
        end
    end

endmodule

`default_nettype wire

// File: exec_unit_props.sv
`default_nettype none

module exec_unit_props (
    input wire logic                      clk,
    input wire logic                      rst,
    input wire logic                      flush,
    input wire logic                      alu_wait,
    input wire logic [exec_pkg::XLEN-1:0] res
);
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    // stall cycles already seen in the current multiply
    logic [STEP_W:0] wait_cycles;

    always_ff @(posedge clk) begin
        if (rst || !alu_wait) begin
            wait_cycles <= '0;
        end else begin
            wait_cycles <= wait_cycles + 1'b1;
        end
    end

    reset_clears_wait: assert property (@(posedge clk) rst |=> !alu_wait)
        else $error("alu_wait high in the cycle after reset");

    wait_bounded: assert property (@(posedge clk) disable iff (rst)
        alu_wait |-> wait_cycles < {1'b0, STEP_W'(MUL_STEPS)})
        else $error("alu_wait held longer than one multiply");

    flush_cancels: assert property (@(posedge clk) disable iff (rst)
        alu_wait && flush |=> !alu_wait)
        else $error("flush while busy did not drop alu_wait");

    res_held: assert property (@(posedge clk) disable iff (rst)
        alu_wait |-> $stable(res))
        else $error("res changed during a multiply");

endmodule

bind exec_unit exec_unit_props u_props (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .alu_wait (alu_wait),
    .res      (res)
);

`default_nettype wire

// File: tb_exec_unit.sv
`default_nettype none

module tb_exec_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    typedef struct packed {
        alu_op_e         op;
        sel_a_e          sel_a;
        sel_b_e          sel_b;
        logic            rs1to32;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] csr;
        logic [XLEN-1:0] imm;
        logic            flush;
    } row_t;

    logic            clk;
    logic            rst;
    logic            flush;
    alu_op_e         operate;
    sel_a_e          sel_a;
    sel_b_e          sel_b;
    logic            rs1to32;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] csr;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] res;
    logic            alu_wait;

    row_t            rows[$];
    integer          seed;
    logic [XLEN-1:0] exp_res;

    exec_unit uut (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .operate  (operate),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .rs1to32  (rs1to32),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr      (csr),
        .imm      (imm),
        .res      (res),
        .alu_wait (alu_wait)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, name, got, want));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("Fail at %0d ns: %s is %b, expected %b", $time, name, got, want));
        end
    endtask

    // roughly one draw in four is all ones, to reach the largest values
    function automatic logic [XLEN-1:0] rand_operand();
        logic [XLEN-1:0] v;
        v = {$random(seed), $random(seed)};
        if (v[63:62] == 2'b11) begin
            v = {XLEN{1'b1}};
        end
        return v;
    endfunction

    // reference model straight from the operation rules
    function automatic logic [XLEN-1:0] expected_res(input row_t r);
        op_word_u           src;
        op_word_u           opa;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        logic [XLEN-1:0]    top;
        logic [5:0]         sh;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] sq;
        logic signed [31:0] slo;
        logic [31:0]        lo_shift;
        logic [XLEN-1:0]    y;
        top = {1'b1, {(XLEN-1){1'b0}}};
        src.word = r.rs1;
        if (r.rs1to32) begin
            src.half.hi = 32'b0;
        end
        a = (r.sel_a == SEL_A_RS1) ? src.word : r.pc;
        case (r.sel_b)
            SEL_B_RS2: b = r.rs2;
            SEL_B_CSR: b = r.csr;
            default:   b = r.imm;
        endcase
        sh = b[5:0];
        sa = a;
        sb = b;
        opa.word = a;
        slo = opa.half.lo;
        lo_shift = slo >>> sh;
        y = '0;
        case (r.op)
            ALU_ADD:      y = a + b;
            ALU_SUB:      y = a - b;
            ALU_RETURN_A: y = a;
            ALU_RETURN_B: y = b;
            ALU_XOR:      y = a ^ b;
            ALU_OR:       y = a | b;
            ALU_AND:      y = a & b;
            ALU_SLL:      y = a << sh;
            ALU_SRL:      y = a >> sh;
            ALU_SRA: begin
                if (r.rs1to32) begin
                    y = {32'b0, lo_shift};
                end else begin
                    y = sa >>> sh;
                end
            end
            // signed order by flipping the sign bit
            ALU_SLT:      y = {63'b0, (a ^ top) < (b ^ top)};
            ALU_SLTU:     y = {63'b0, a < b};
            ALU_EQ:       y = {63'b0, a == b};
            ALU_LOE:      y = {63'b0, (a ^ top) >= (b ^ top)};
            ALU_LOEU:     y = {63'b0, a >= b};
            ALU_MUL:      y = a * b;
            ALU_DIV: begin
                if (b == '0) begin
                    y = {XLEN{1'b1}};
                end else if (a == top && b == {XLEN{1'b1}}) begin
                    y = top;
                end else begin
                    sq = sa / sb;
                    y = sq;
                end
            end
            ALU_DIVU:     y = (b == '0) ? {XLEN{1'b1}} : a / b;
            ALU_REM: begin
                if (b == '0) begin
                    y = a;
                end else if (a == top && b == {XLEN{1'b1}}) begin
                    y = '0;
                end else begin
                    sq = sa % sb;
                    y = sq;
                end
            end
            ALU_REMU:     y = (b == '0) ? a : a % b;
            default:      y = '0;
        endcase
        return y;
    endfunction

    task automatic append_row(input alu_op_e op, input sel_a_e sa, input sel_b_e sb,
                              input logic r32, input logic [XLEN-1:0] rs1_v,
                              input logic [XLEN-1:0] rs2_v, input logic fl);
        rows.push_back(row_t'{op, sa, sb, r32, rand_operand(), rs1_v, rs2_v,
                              rand_operand(), rand_operand(), fl});
    endtask

    task automatic reg_row(input alu_op_e op, input logic [XLEN-1:0] rs1_v,
                           input logic [XLEN-1:0] rs2_v, input logic r32, input logic fl);
        append_row(op, SEL_A_RS1, SEL_B_RS2, r32, rs1_v, rs2_v, fl);
    endtask

    task automatic build_table();
        logic [XLEN-1:0] top;
        logic [XLEN-1:0] ones;
        alu_op_e         code;
        top = {1'b1, {(XLEN-1){1'b0}}};
        ones = {XLEN{1'b1}};
        // every single-cycle opcode, both a selects, three b selects, rs1to32 off and on
        for (int k = 0; k < 20 * 12; k++) begin
            code = alu_op_e'(5'(k / 12));
            if (code != ALU_MUL) begin
                append_row(code, sel_a_e'(2'((k / 6) % 2)), sel_b_e'(2'((k / 2) % 3)),
                           k[0], rand_operand(), rand_operand(), 1'b0);
            end
        end
        // shift amount masking and the 32-bit arithmetic shift
        reg_row(ALU_SLL, 64'h1, 64'h7fc1, 1'b0, 1'b0);
        reg_row(ALU_SRL, top, 64'hff, 1'b0, 1'b0);
        reg_row(ALU_SRA, 64'hffff_ffff_8000_0000, 64'h44, 1'b1, 1'b0);
        reg_row(ALU_SRA, top, 64'h3f, 1'b0, 1'b0);
        reg_row(ALU_SLT, top, 64'h1, 1'b0, 1'b0);
        reg_row(ALU_SLTU, top, 64'h1, 1'b0, 1'b0);
        reg_row(ALU_LOE, top, 64'h1, 1'b0, 1'b0);
        reg_row(ALU_LOEU, top, 64'h1, 1'b0, 1'b0);
        // zero divisor and signed overflow
        reg_row(ALU_DIV, 64'd77, 64'd0, 1'b0, 1'b0);
        reg_row(ALU_DIVU, 64'd77, 64'd0, 1'b0, 1'b0);
        reg_row(ALU_REM, 64'd77, 64'd0, 1'b0, 1'b0);
        reg_row(ALU_REMU, 64'd77, 64'd0, 1'b0, 1'b0);
        reg_row(ALU_DIV, top, ones, 1'b0, 1'b0);
        reg_row(ALU_REM, top, ones, 1'b0, 1'b0);
        // back-to-back multiplies, then a cancelled one, then normal work
        reg_row(ALU_MUL, ones, ones, 1'b0, 1'b0);
        reg_row(ALU_MUL, top, 64'h3, 1'b0, 1'b0);
        reg_row(ALU_MUL, 64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321, 1'b0, 1'b0);
        reg_row(ALU_MUL, ones, 64'h5, 1'b0, 1'b1);
        reg_row(ALU_ADD, 64'd40, 64'd2, 1'b0, 1'b0);
        reg_row(ALU_SUB, 64'd40, 64'd2, 1'b0, 1'b1);
        for (int k = 0; k < 40; k++) begin
            append_row(alu_op_e'(5'($unsigned($random(seed)) % 20)),
                       sel_a_e'(2'($unsigned($random(seed)) % 2)),
                       sel_b_e'(2'($unsigned($random(seed)) % 3)),
                       1'($random(seed)), rand_operand(), rand_operand(),
                       ($random(seed) & 7) == 0);
        end
    endtask

    task automatic drive_row(input row_t r);
        operate = r.op;
        sel_a = r.sel_a;
        sel_b = r.sel_b;
        rs1to32 = r.rs1to32;
        pc = r.pc;
        rs1 = r.rs1;
        rs2 = r.rs2;
        csr = r.csr;
        imm = r.imm;
        // for a multiply the flag means a cancel partway through
        flush = (r.op == ALU_MUL) ? 1'b0 : r.flush;
    endtask

    task automatic issue_single(input row_t r);
        @(negedge clk);
        check_bit("alu_wait", alu_wait, 1'b0);
        if (!r.flush) begin
            exp_res = expected_res(r);
        end
        check_word("res", res, exp_res);
    endtask

    task automatic await_multiply(input row_t r);
        logic [XLEN-1:0] product;
        int              high;
        product = expected_res(r);
        high = 0;
        @(negedge clk);
        check_bit("alu_wait", alu_wait, 1'b1);
        // fresh operands while busy, the running product must ignore them
        pc = rand_operand();
        rs1 = rand_operand();
        rs2 = rand_operand();
        csr = rand_operand();
        imm = rand_operand();
        rs1to32 = ~rs1to32;
        while (alu_wait && high <= 2 * MUL_STEPS) begin
            high++;
            if (r.flush && high == 20) begin
                flush = 1'b1;
            end
            @(negedge clk);
        end
        flush = 1'b0;
        if (alu_wait) begin
            abort_run("alu_wait did not fall within the multiply timeout");
        end else if (r.flush && high != 20) begin
            abort_run($sformatf("flushed multiply kept alu_wait high for %0d cycles", high));
        end else if (!r.flush && high != MUL_STEPS) begin
            abort_run($sformatf("multiply kept alu_wait high for %0d cycles, not %0d",
                                high, MUL_STEPS));
        end else begin
            if (!r.flush) begin
                exp_res = product;
            end
            check_word("res", res, exp_res);
        end
    endtask

    initial begin
        seed = 32'h6bc638fe;
        rst = 1'b1;
        flush = 1'b0;
        operate = ALU_ADD;
        sel_a = SEL_A_RS1;
        sel_b = SEL_B_RS2;
        rs1to32 = 1'b0;
        pc = '0;
        rs1 = '0;
        rs2 = '0;
        csr = '0;
        imm = '0;
        exp_res = '0;
        build_table();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_bit("alu_wait", alu_wait, 1'b0);
        check_word("res", res, exp_res);
        foreach (rows[i]) begin
            drive_row(rows[i]);
            if (rows[i].op == ALU_MUL) begin
                await_multiply(rows[i]);
            end else begin
                issue_single(rows[i]);
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: exec_unit.f
exec_pkg.sv
alu_logic.sv
mul_shift_add.sv
mul_step_counter.sv
exec_ctrl.sv
exec_unit.sv
exec_unit_props.sv
tb_exec_unit.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_unit -f exec_unit.f
out=$(./obj_dir/Vtb_exec_unit 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1
